// File: Bender.yml
package:
  name: mem_controller

export_include_dirs:
  - src

sources:
  - src/busPkg.sv
  - src/memcPkg.sv
  - src/reqArbiter.sv
  - src/transferTable.sv
  - src/readRouter.sv
  - src/writeIssuer.sv
  - src/memController.sv
  - target: test
    files:
      - test/memControllerTb.sv

// File: src/busPkg.sv
`default_nettype none
`include "memc_config.svh"

package busPkg;

    typedef logic [`MEMC_ID_W-1:0] busId;
    typedef logic [`BUS_DATA_W-1:0] beat;
    typedef logic [`BUS_DATA_W/8-1:0] strobe;

    typedef enum logic [1:0] {
        burstFixed,
        burstIncr
    } burstKind;

    // Shared by read and write address channels
    typedef struct packed {
        busId id;
        logic [`BUS_ADDR_W-1:0] addr;
        logic [7:0] len;
        logic [2:0] size;
        burstKind burst;
    } addrChan;

    typedef struct packed {
        beat data;
        strobe strb;
        logic last;
    } writeChan;

    typedef struct packed {
        busId id;
        beat data;
        logic last;
    } readChan;

endpackage

`default_nettype wire

// File: src/memController.sv
`timescale 1ns/100ps
`default_nettype none
`include "memc_config.svh"

module memController (
    input wire clk,
    input wire rst,

    // Clients and data cache
    input wire memcPkg::memReq req[`MEMC_NUM_PORTS],
    output logic [`MEMC_NUM_PORTS-1:0] stall,
    output memcPkg::loadResult loadRes,
    output memcPkg::storeResult storeRes,
    output memcPkg::fillDone fill,
    output memcPkg::cacheWrite cacheWr,

    // External bus
    output busPkg::addrChan ar,
    output logic arValid,
    input wire arReady,
    output busPkg::addrChan aw,
    output logic awValid,
    input wire awReady,
    output busPkg::writeChan w,
    output logic wValid,
    input wire wReady,
    input wire busPkg::readChan r,
    input wire rValid,
    output logic rReady,
    input wire busPkg::busId bId,
    input wire bValid,
    output logic bReady
);

    memcPkg::transferEntry entries[`MEMC_NUM_TRANS];
    memcPkg::enqReq enq;
    memcPkg::storeOffer offer;
    memcPkg::slotFree storeFree;
    memcPkg::slotFree beatFree;
    logic storeTaken;

    reqArbiter arbiter (
        .req(req),
        .entries(entries),
        .stall(stall),
        .enq(enq)
    );

    transferTable xferTable (
        .clk(clk),
        .rst(rst),
        .enq(enq),
        .storeTaken(storeTaken),
        .storeFree(storeFree),
        .beatFree(beatFree),
        .entries(entries),
        .ar(ar),
        .arValid(arValid),
        .arReady(arReady),
        .offer(offer)
    );

    readRouter router (
        .clk(clk),
        .rst(rst),
        .r(r),
        .rValid(rValid),
        .rReady(rReady),
        .entries(entries),
        .cacheWr(cacheWr),
        .loadRes(loadRes),
        .fill(fill),
        .beatFree(beatFree)
    );

    writeIssuer issuer (
        .clk(clk),
        .rst(rst),
        .offer(offer),
        .storeTaken(storeTaken),
        .aw(aw),
        .awValid(awValid),
        .awReady(awReady),
        .w(w),
        .wValid(wValid),
        .wReady(wReady),
        .bId(bId),
        .bValid(bValid),
        .bReady(bReady),
        .storeRes(storeRes),
        .storeFree(storeFree)
    );

endmodule

`default_nettype wire

// File: src/memcPkg.sv
`default_nettype none
`include "memc_config.svh"

package memcPkg;

    typedef enum logic [1:0] {
        cmdNone,
        cmdFill,
        cmdLoad,
        cmdStore
    } memCmd;

    typedef logic [`MEMC_ID_W-1:0] slotIdx;
    typedef logic [`BUS_ADDR_W-1:0] busAddr;
    typedef logic [`CACHE_LINE_W-1:0] lineIdx;
    typedef logic [`BEAT_IDX_W-1:0] beatIdx;
    typedef logic [`TAG_W-1:0] clientTag;
    typedef logic [31:0] word;

    // Cache word address in beat units
    typedef struct packed {
        lineIdx line;
        beatIdx beat;
    } cacheAddr;

    typedef struct packed {
        memCmd cmd;
        busAddr extAddr;
        lineIdx line;
        word data;
        clientTag tag;
    } memReq;

    typedef struct packed {
        logic valid;
        memCmd cmd;
        busAddr extAddr;
        lineIdx line;
        word data;
        clientTag tag;
        logic needRead;
        logic needWrite;
    } transferEntry;

    typedef struct packed {
        logic valid;
        slotIdx idx;
        memReq req;
    } enqReq;

    typedef struct packed {
        logic valid;
        slotIdx idx;
    } slotFree;

    typedef struct packed {
        logic valid;
        clientTag tag;
        word data;
    } loadResult;

    typedef struct packed {
        logic valid;
        clientTag tag;
    } storeResult;

    typedef struct packed {
        logic valid;
        clientTag tag;
    } fillDone;

    typedef struct packed {
        logic we;
        cacheAddr addr;
        busPkg::beat data;
    } cacheWrite;

    typedef struct packed {
        logic valid;
        slotIdx idx;
        busAddr extAddr;
        word data;
        clientTag tag;
    } storeOffer;

endpackage

`default_nettype wire

// File: src/memc_config.svh
`ifndef MEMC_CONFIG_SVH
`define MEMC_CONFIG_SVH

// Client ports and transfer slots
`define MEMC_NUM_PORTS 2
`define MEMC_NUM_TRANS 4
`define MEMC_ID_W 2

// External bus
`define BUS_ADDR_W 32
`define BUS_DATA_W 128

// Cache geometry, 64 byte lines
`define LINE_BEATS 4
`define BEAT_IDX_W 2
`define CACHE_LINE_W 8

`define TAG_W 4

`endif

// File: src/readRouter.sv
`timescale 1ns/100ps
`default_nettype none
`include "memc_config.svh"

module readRouter (
    input wire clk,
    input wire rst,
    input wire busPkg::readChan r,
    input wire rValid,
    output logic rReady,
    input wire memcPkg::transferEntry entries[`MEMC_NUM_TRANS],
    output memcPkg::cacheWrite cacheWr,
    output memcPkg::loadResult loadRes,
    output memcPkg::fillDone fill,
    output memcPkg::slotFree beatFree
);

    memcPkg::beatIdx beatCnt[`MEMC_NUM_TRANS];
    memcPkg::transferEntry cur;
    logic beatIn;
    logic isFill;

    assign rReady = 1'b1;
    assign beatIn = rValid && rReady;
    assign cur = entries[r.id];
    assign isFill = cur.cmd == memcPkg::cmdFill;

    // Slot is done after a load beat or the last fill beat
    always_comb begin
        beatFree.valid = beatIn && (!isFill || r.last);
        beatFree.idx = memcPkg::slotIdx'(r.id);
    end

    always_ff @(posedge clk) begin
        cacheWr.we <= 1'b0;
        loadRes.valid <= 1'b0;
        fill.valid <= 1'b0;

        if (beatIn) begin
            if (isFill) begin
                cacheWr.we <= 1'b1;
                cacheWr.addr.line <= cur.line;
                cacheWr.addr.beat <= beatCnt[r.id];
                cacheWr.data <= r.data;
                beatCnt[r.id] <= r.last ? '0 : beatCnt[r.id] + 1'b1;
                if (r.last) begin
                    fill.valid <= 1'b1;
                    fill.tag <= cur.tag;
                end
            end else begin
                loadRes.valid <= 1'b1;
                loadRes.tag <= cur.tag;
                loadRes.data <= r.data[$bits(memcPkg::word)-1:0];
            end
        end

        if (rst) begin
            cacheWr.we <= 1'b0;
            loadRes.valid <= 1'b0;
            fill.valid <= 1'b0;
            for (int i = 0; i < `MEMC_NUM_TRANS; i++)
                beatCnt[i] <= '0;
        end
    end

endmodule

`default_nettype wire

// File: src/reqArbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "memc_config.svh"

module reqArbiter (
    input wire memcPkg::memReq req[`MEMC_NUM_PORTS],
    input wire memcPkg::transferEntry entries[`MEMC_NUM_TRANS],
    output logic [`MEMC_NUM_PORTS-1:0] stall,
    output memcPkg::enqReq enq
);

    memcPkg::slotIdx freeIdx;
    logic freeValid;
    logic [`MEMC_NUM_PORTS-1:0] collide;

    always_comb begin
        freeIdx = '0;
        freeValid = 1'b0;
        for (int i = 0; i < `MEMC_NUM_TRANS; i++) begin
            if (!freeValid && !entries[i].valid) begin
                freeIdx = memcPkg::slotIdx'(i);
                freeValid = 1'b1;
            end
        end
    end

    // A line may only have one fill in flight
    always_comb begin
        for (int p = 0; p < `MEMC_NUM_PORTS; p++) begin
            collide[p] = 1'b0;
            for (int i = 0; i < `MEMC_NUM_TRANS; i++) begin
                if (req[p].cmd == memcPkg::cmdFill && entries[i].valid &&
                        entries[i].cmd == memcPkg::cmdFill &&
                        entries[i].line == req[p].line) begin
                    collide[p] = 1'b1;
                end
            end
        end
    end

    // Port 0 has priority
    always_comb begin
        stall = '1;
        enq.valid = 1'b0;
        enq.idx = freeIdx;
        enq.req = req[0];
        if (freeValid) begin
            for (int p = 0; p < `MEMC_NUM_PORTS; p++) begin
                if (!enq.valid && req[p].cmd != memcPkg::cmdNone && !collide[p]) begin
                    enq.valid = 1'b1;
                    enq.req = req[p];
                    stall[p] = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/transferTable.sv
`timescale 1ns/100ps
`default_nettype none
`include "memc_config.svh"

module transferTable (
    input wire clk,
    input wire rst,
    input wire memcPkg::enqReq enq,
    input wire storeTaken,
    input wire memcPkg::slotFree storeFree,
    input wire memcPkg::slotFree beatFree,
    output memcPkg::transferEntry entries[`MEMC_NUM_TRANS],
    output busPkg::addrChan ar,
    output logic arValid,
    input wire arReady,
    output memcPkg::storeOffer offer
);

    localparam int LineOffW = $clog2(`LINE_BEATS * `BUS_DATA_W / 8);
    localparam int BeatSize = $clog2(`BUS_DATA_W / 8);

    memcPkg::slotIdx arIdx;
    memcPkg::slotIdx nextIdx;
    logic nextValid;
    busPkg::addrChan nextAr;

    // Lowest slot needing a read, not counting the one already on the bus
    always_comb begin
        nextIdx = '0;
        nextValid = 1'b0;
        for (int i = 0; i < `MEMC_NUM_TRANS; i++) begin
            if (!nextValid && entries[i].valid && entries[i].needRead &&
                    !(arValid && arIdx == memcPkg::slotIdx'(i))) begin
                nextIdx = memcPkg::slotIdx'(i);
                nextValid = 1'b1;
            end
        end
    end

    always_comb begin
        nextAr.id = busPkg::busId'(nextIdx);
        if (entries[nextIdx].cmd == memcPkg::cmdFill) begin
            nextAr.addr = {entries[nextIdx].extAddr[`BUS_ADDR_W-1:LineOffW], {LineOffW{1'b0}}};
            nextAr.len = 8'(`LINE_BEATS - 1);
            nextAr.size = 3'(BeatSize);
            nextAr.burst = busPkg::burstIncr;
        end else begin
            nextAr.addr = entries[nextIdx].extAddr;
            nextAr.len = 8'd0;
            nextAr.size = 3'd2;
            nextAr.burst = busPkg::burstFixed;
        end
    end

    always_comb begin
        memcPkg::slotIdx idx;
        logic found;
        idx = '0;
        found = 1'b0;
        for (int i = 0; i < `MEMC_NUM_TRANS; i++) begin
            if (!found && entries[i].valid && entries[i].needWrite) begin
                idx = memcPkg::slotIdx'(i);
                found = 1'b1;
            end
        end
        offer.valid = found;
        offer.idx = idx;
        offer.extAddr = entries[idx].extAddr;
        offer.data = entries[idx].data;
        offer.tag = entries[idx].tag;
    end

    always_ff @(posedge clk) begin
        // AR payload stays put until accepted
        if (!arValid || arReady) begin
            arValid <= nextValid;
            ar <= nextAr;
            arIdx <= nextIdx;
        end

        if (arValid && arReady)
            entries[arIdx].needRead <= 1'b0;
        if (storeTaken)
            entries[offer.idx].needWrite <= 1'b0;

        if (storeFree.valid)
            entries[storeFree.idx].valid <= 1'b0;
        if (beatFree.valid)
            entries[beatFree.idx].valid <= 1'b0;

        if (enq.valid) begin
            entries[enq.idx].valid <= 1'b1;
            entries[enq.idx].cmd <= enq.req.cmd;
            entries[enq.idx].extAddr <= enq.req.extAddr;
            entries[enq.idx].line <= enq.req.line;
            entries[enq.idx].data <= enq.req.data;
            entries[enq.idx].tag <= enq.req.tag;
            entries[enq.idx].needRead <= enq.req.cmd == memcPkg::cmdFill ||
                enq.req.cmd == memcPkg::cmdLoad;
            entries[enq.idx].needWrite <= enq.req.cmd == memcPkg::cmdStore;
        end

        if (rst) begin
            arValid <= 1'b0;
            for (int i = 0; i < `MEMC_NUM_TRANS; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].needRead <= 1'b0;
                entries[i].needWrite <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/writeIssuer.sv
`timescale 1ns/100ps
`default_nettype none

module writeIssuer (
    input wire clk,
    input wire rst,
    input wire memcPkg::storeOffer offer,
    output logic storeTaken,
    output busPkg::addrChan aw,
    output logic awValid,
    input wire awReady,
    output busPkg::writeChan w,
    output logic wValid,
    input wire wReady,
    input wire busPkg::busId bId,
    input wire bValid,
    output logic bReady,
    output memcPkg::storeResult storeRes,
    output memcPkg::slotFree storeFree
);

    typedef enum logic [1:0] {
        wrIdle,
        wrAddr,
        wrData,
        wrResp
    } wrState;

    wrState state;
    memcPkg::storeOffer held;
    logic respHit;

    assign bReady = 1'b1;
    assign storeTaken = state == wrIdle && offer.valid;
    assign respHit = state == wrResp && bValid && bReady && bId == busPkg::busId'(held.idx);
    assign awValid = state == wrAddr;
    assign wValid = state == wrData;

    // Single word, FIXED burst
    always_comb begin
        aw.id = busPkg::busId'(held.idx);
        aw.addr = held.extAddr;
        aw.len = 8'd0;
        aw.size = 3'd2;
        aw.burst = busPkg::burstFixed;
        w.data = busPkg::beat'(held.data);
        w.strb = busPkg::strobe'(4'hF);
        w.last = 1'b1;
        storeFree.valid = respHit;
        storeFree.idx = held.idx;
    end

    always_ff @(posedge clk) begin
        storeRes.valid <= 1'b0;
        case (state)
            wrIdle: begin
                if (storeTaken) begin
                    held <= offer;
                    state <= wrAddr;
                end
            end
            wrAddr: if (awReady) state <= wrData;
            wrData: if (wReady) state <= wrResp;
            wrResp: begin
                if (respHit) begin
                    storeRes.valid <= 1'b1;
                    storeRes.tag <= held.tag;
                    state <= wrIdle;
                end
            end
            default: state <= wrIdle;
        endcase

        if (rst) begin
            state <= wrIdle;
            storeRes.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: test/memControllerTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "memc_config.svh"

module memControllerTb;

    localparam int TestCount = 40;
    // Worst case for one request under random back-pressure
    localparam int WorstReqNs = 1000;
    localparam int TimeoutNs = TestCount * WorstReqNs;
    localparam int NumTags = 1 << `TAG_W;
    localparam int RandPerPort = 12;

    logic clk;
    logic rst;
    memcPkg::memReq req[`MEMC_NUM_PORTS];
    logic [`MEMC_NUM_PORTS-1:0] stall;
    memcPkg::loadResult loadRes;
    memcPkg::storeResult storeRes;
    memcPkg::fillDone fill;
    memcPkg::cacheWrite cacheWr;
    busPkg::addrChan ar;
    logic arValid;
    logic arReady;
    busPkg::addrChan aw;
    logic awValid;
    logic awReady;
    busPkg::writeChan w;
    logic wValid;
    logic wReady;
    busPkg::readChan r;
    logic rValid;
    logic rReady;
    busPkg::busId bId;
    logic bValid;
    logic bReady;

    // Expected items, indexed by client tag
    memcPkg::memCmd pendKind[NumTags];
    memcPkg::busAddr pendAddr[NumTags];
    memcPkg::word pendData[NumTags];
    memcPkg::lineIdx pendLine[NumTags];
    int fillBeats[NumTags];
    time acceptTime[NumTags];
    time fillTime[NumTags];
    memcPkg::clientTag nextTag;
    logic [31:0] rngState;
    logic arHold;

    // Bus model state
    busPkg::addrChan readQ[$];
    int beatNum;
    int rGap;
    logic bPending;
    int bDelay;
    busPkg::busId bNextId;

    memController dut (
        .clk(clk),
        .rst(rst),
        .req(req),
        .stall(stall),
        .loadRes(loadRes),
        .storeRes(storeRes),
        .fill(fill),
        .cacheWr(cacheWr),
        .ar(ar),
        .arValid(arValid),
        .arReady(arReady),
        .aw(aw),
        .awValid(awValid),
        .awReady(awReady),
        .w(w),
        .wValid(wValid),
        .wReady(wReady),
        .r(r),
        .rValid(rValid),
        .rReady(rReady),
        .bId(bId),
        .bValid(bValid),
        .bReady(bReady)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic int unsigned randBelow(input int unsigned n);
        return randWord() % n;
    endfunction

    // Memory content of the word at a byte address
    function automatic memcPkg::word memWord(input memcPkg::busAddr a);
        logic [31:0] x;
        x = {a[31:2], 2'b00} * 32'h9E37_79B1;
        x = x ^ (x >> 15) ^ 32'h5A5A_0F0F;
        return x + {a[15:0], a[31:16]};
    endfunction

    function automatic memcPkg::busAddr lineBase(input memcPkg::busAddr a);
        return {a[31:6], 6'b0};
    endfunction

    // Bus beat holding the four words around a
    function automatic busPkg::beat lineBeat(input memcPkg::busAddr a);
        busPkg::beat b;
        for (int k = 0; k < 4; k++)
            b[32*k +: 32] = memWord({a[31:4], 4'h0} + 32'(4 * k));
        return b;
    endfunction

    function automatic int countOpen();
        int open;
        open = 0;
        for (int t = 0; t < NumTags; t++)
            if (pendKind[t] != memcPkg::cmdNone)
                open++;
        return open;
    endfunction

    task automatic reportMismatch(input string msg);
        $display("FAIL %0d ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic reportProblem(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic buildReq(input memcPkg::memCmd cmd, input memcPkg::busAddr a,
            output memcPkg::memReq q);
        q.cmd = cmd;
        q.line = a[13:6];
        q.data = randWord();
        q.tag = nextTag;
        // Stores get an address unique to their tag
        if (cmd == memcPkg::cmdStore)
            q.extAddr = {a[31:6], nextTag, 2'b00};
        else if (cmd == memcPkg::cmdLoad)
            q.extAddr = {a[31:2], 2'b00};
        else
            q.extAddr = a;
        nextTag = nextTag + 1'b1;
    endtask

    task automatic registerReq(input memcPkg::memReq q, input time at);
        assert (pendKind[q.tag] == memcPkg::cmdNone)
            else reportProblem("A client tag was reused while still outstanding.");
        pendKind[q.tag] = q.cmd;
        pendAddr[q.tag] = q.extAddr;
        pendData[q.tag] = q.data;
        pendLine[q.tag] = q.line;
        fillBeats[q.tag] = 0;
        fillTime[q.tag] = 0;
        acceptTime[q.tag] = at;
    endtask

    task automatic waitAccept(input int port, input memcPkg::memReq q);
        time at;
        do
            @(posedge clk);
        while (stall[port]);
        at = $time;
        #1 req[port] = '0;
        registerReq(q, at);
    endtask

    task automatic sendReq(input int port, input memcPkg::memCmd cmd,
            input memcPkg::busAddr a, output memcPkg::clientTag tag);
        memcPkg::memReq q;
        buildReq(cmd, a, q);
        tag = q.tag;
        @(posedge clk);
        #1 req[port] = q;
        waitAccept(port, q);
    endtask

    task automatic waitIdle();
        do
            @(posedge clk);
        while (countOpen() != 0);
    endtask

    task automatic randomTraffic(input int port);
        memcPkg::memCmd cmd;
        memcPkg::busAddr a;
        memcPkg::clientTag tag;
        int unsigned pick;
        repeat (RandPerPort) begin
            pick = randBelow(3);
            cmd = pick == 0 ? memcPkg::cmdFill :
                pick == 1 ? memcPkg::cmdLoad : memcPkg::cmdStore;
            // Fills share a few lines so that they collide
            a = cmd == memcPkg::cmdFill ? randWord() & 32'h0000_00FF : randWord();
            sendReq(port, cmd, a, tag);
            repeat (randBelow(3)) @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Memory side of the bus
    always @(posedge clk) begin : busModel
        busPkg::addrChan head;
        memcPkg::busAddr beatAddr;
        if (rst) begin
            readQ.delete();
            beatNum = 0;
            rGap = 2;
            bPending = 1'b0;
            bDelay = 0;
            bNextId = '0;
        end else begin
            if (arValid && arReady)
                readQ.push_back(ar);
            if (rValid && rReady) begin
                if (r.last) begin
                    void'(readQ.pop_front());
                    beatNum = 0;
                    rGap = randBelow(4);
                end else begin
                    beatNum++;
                    rGap = randBelow(2);
                end
            end else if (rGap > 0) begin
                rGap--;
            end
            if (awValid && awReady)
                bNextId = aw.id;
            if (wValid && wReady) begin
                bPending = 1'b1;
                bDelay = randBelow(4);
            end
            if (bValid && bReady)
                bPending = 1'b0;
            else if (bPending && bDelay > 0)
                bDelay--;
        end
        #1;
        arReady = !arHold && randBelow(4) != 0;
        awReady = randBelow(3) != 0;
        wReady = randBelow(3) != 0;
        rValid = readQ.size() > 0 && rGap == 0;
        if (rValid) begin
            head = readQ[0];
            beatAddr = head.addr + 32'(beatNum * 16);
            r.id = head.id;
            r.data = lineBeat(beatAddr);
            if (head.burst == busPkg::burstFixed)
                r.data[31:0] = memWord(head.addr);
            r.last = beatNum == int'(head.len);
        end
        bValid = bPending && bDelay == 0;
        bId = bNextId;
    end

    always @(posedge clk) begin : compare
        logic found;
        int ft;
        int curStore;
        logic arWait;
        logic awWait;
        logic wWait;
        logic bPrev;
        busPkg::addrChan arPrev;
        busPkg::addrChan awPrev;
        busPkg::writeChan wPrev;
        if (!rst) begin
            assert (rReady && bReady) else reportMismatch("rReady or bReady went low");
            // Payloads held until accepted
            if (arWait)
                assert (arValid && ar == arPrev) else reportMismatch("AR changed while waiting");
            if (awWait)
                assert (awValid && aw == awPrev) else reportMismatch("AW changed while waiting");
            if (wWait)
                assert (wValid && w == wPrev) else reportMismatch("W changed while waiting");

            if (arValid && arReady) begin
                found = 1'b0;
                for (int t = 0; t < NumTags; t++) begin
                    if (ar.burst == busPkg::burstIncr && pendKind[t] == memcPkg::cmdFill &&
                            lineBase(pendAddr[t]) == ar.addr)
                        found = 1'b1;
                    if (ar.burst == busPkg::burstFixed && pendKind[t] == memcPkg::cmdLoad &&
                            pendAddr[t] == ar.addr)
                        found = 1'b1;
                end
                assert (found) else reportProblem("A read address came with no matching request.");
                if (ar.burst == busPkg::burstIncr)
                    assert (ar.len == 8'd3 && ar.size == 3'd4)
                        else reportMismatch($sformatf("fill AR len %0d size %0d", ar.len, ar.size));
                else
                    assert (ar.len == 8'd0 && ar.size == 3'd2)
                        else reportMismatch($sformatf("load AR len %0d size %0d", ar.len, ar.size));
            end

            if (awValid && awReady) begin
                found = 1'b0;
                for (int t = 0; t < NumTags; t++) begin
                    if (!found && pendKind[t] == memcPkg::cmdStore && pendAddr[t] == aw.addr) begin
                        found = 1'b1;
                        curStore = t;
                    end
                end
                assert (found) else reportProblem("A write address came with no matching store.");
                assert (aw.len == 8'd0 && aw.size == 3'd2 && aw.burst == busPkg::burstFixed)
                    else reportMismatch($sformatf("AW encoding wrong at %h", aw.addr));
            end
            if (wValid && wReady)
                assert (w.data[31:0] == pendData[curStore] && w.strb == 16'h000F && w.last)
                    else reportMismatch($sformatf("W data %h strb %h, expected %h",
                        w.data[31:0], w.strb, pendData[curStore]));
            if (storeRes.valid) begin
                assert (bPrev)
                    else reportProblem("A store result came without a write response before it.");
                assert (pendKind[storeRes.tag] == memcPkg::cmdStore && storeRes.tag == curStore)
                    else reportMismatch($sformatf("store result tag %0d", storeRes.tag));
                pendKind[storeRes.tag] = memcPkg::cmdNone;
            end

            if (loadRes.valid) begin
                assert (pendKind[loadRes.tag] == memcPkg::cmdLoad)
                    else reportProblem("A load result came for a tag with no load outstanding.");
                assert (loadRes.data == memWord(pendAddr[loadRes.tag]))
                    else reportMismatch($sformatf("load tag %0d data %h, expected %h",
                        loadRes.tag, loadRes.data, memWord(pendAddr[loadRes.tag])));
                pendKind[loadRes.tag] = memcPkg::cmdNone;
            end

            if (cacheWr.we) begin
                found = 1'b0;
                for (int t = 0; t < NumTags; t++) begin
                    if (!found && pendKind[t] == memcPkg::cmdFill &&
                            pendLine[t] == cacheWr.addr.line) begin
                        found = 1'b1;
                        ft = t;
                    end
                end
                assert (found) else reportProblem("A cache write came for a line with no fill.");
                assert (cacheWr.addr.beat == fillBeats[ft] && cacheWr.data ==
                        lineBeat(lineBase(pendAddr[ft]) + 32'(16 * fillBeats[ft])))
                    else reportMismatch($sformatf("cache write line %0d beat %0d wrong",
                        cacheWr.addr.line, cacheWr.addr.beat));
                fillBeats[ft]++;
            end
            if (fill.valid) begin
                assert (pendKind[fill.tag] == memcPkg::cmdFill && fillBeats[fill.tag] == 4)
                    else reportMismatch($sformatf("fill pulse tag %0d", fill.tag));
                pendKind[fill.tag] = memcPkg::cmdNone;
                fillTime[fill.tag] = $time;
            end
        end
        arWait = !rst && arValid && !arReady;
        awWait = !rst && awValid && !awReady;
        wWait = !rst && wValid && !wReady;
        bPrev = !rst && bValid && bReady;
        arPrev = ar;
        awPrev = aw;
        wPrev = w;
    end

    initial begin
        #(TimeoutNs);
        $display("Timeout: the run did not finish within the time limit");
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        memcPkg::clientTag tagA;
        memcPkg::clientTag tagB;
        memcPkg::memReq qa;
        memcPkg::memReq qb;
        time at;
        rst = 1'b1;
        for (int p = 0; p < `MEMC_NUM_PORTS; p++)
            req[p] = '0;
        arReady = 1'b0;
        awReady = 1'b0;
        wReady = 1'b0;
        r = '0;
        rValid = 1'b0;
        bId = '0;
        bValid = 1'b0;
        for (int t = 0; t < NumTags; t++) begin
            pendKind[t] = memcPkg::cmdNone;
            acceptTime[t] = 0;
            fillTime[t] = 0;
        end
        rngState = 32'd31;
        nextTag = '0;
        arHold = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        sendReq(0, memcPkg::cmdLoad, 32'h0000_1234, tagA);
        waitIdle();
        sendReq(1, memcPkg::cmdStore, 32'h0001_0000, tagA);
        waitIdle();
        sendReq(0, memcPkg::cmdFill, 32'h0000_2A48, tagA);
        waitIdle();

        // Same cycle on both ports
        buildReq(memcPkg::cmdLoad, 32'h0000_0400, qa);
        buildReq(memcPkg::cmdStore, 32'h0000_0800, qb);
        @(posedge clk);
        #1;
        req[0] = qa;
        req[1] = qb;
        @(posedge clk);
        assert (stall == 2'b10) else reportMismatch($sformatf("stall %b, expected 10", stall));
        at = $time;
        #1 req[0] = '0;
        registerReq(qa, at);
        waitAccept(1, qb);
        waitIdle();

        // Second fill to a line already in flight
        sendReq(0, memcPkg::cmdFill, 32'h0000_3C00, tagA);
        sendReq(1, memcPkg::cmdFill, 32'h0000_3C20, tagB);
        waitIdle();
        assert (fillTime[tagA] != 0 && fillTime[tagA] <= acceptTime[tagB])
            else reportMismatch("second fill accepted before the first fill finished");

        // All slots busy
        arHold = 1'b1;
        repeat (4) sendReq(0, memcPkg::cmdLoad, randWord(), tagA);
        buildReq(memcPkg::cmdLoad, 32'h0000_5000, qa);
        buildReq(memcPkg::cmdStore, 32'h0000_6000, qb);
        @(posedge clk);
        #1;
        req[0] = qa;
        req[1] = qb;
        repeat (3) begin
            @(posedge clk);
            assert (stall == 2'b11) else reportMismatch($sformatf("stall %b with table full", stall));
        end
        arHold = 1'b0;
        fork
            waitAccept(0, qa);
            waitAccept(1, qb);
        join
        waitIdle();

        fork
            randomTraffic(0);
            randomTraffic(1);
        join
        waitIdle();
        repeat (20) @(posedge clk);

        if (countOpen() == 0 && !arValid && !awValid && !wValid) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "Requests were still open at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/busPkg.sv
src/memcPkg.sv
src/reqArbiter.sv
src/transferTable.sv
src/readRouter.sv
src/writeIssuer.sv
src/memController.sv
test/memControllerTb.sv
